// ==== guitar_recorder.f ====
src/guitar_pkg.sv
src/tempo_divider.sv
src/note_capture.sv
src/note_memory.sv
src/mode_control.sv
src/note_display.sv
src/guitar_recorder.sv
tests/tb_guitar_recorder.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f guitar_recorder.f --top-module tb_guitar_recorder \
	-Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== tests/tb_guitar_recorder.sv ====
// clk_hz lowered to 60000 so a beat lasts 16363 cycles at speed 7; each wait gives up after its own bound
`timescale 1ns/100ps

module tb_guitar_recorder;

	localparam int CLK_HZ = 60000;
	localparam int NPAT = 8;
	localparam int HOLD = 3;           // button hold in cycles
	localparam int STATE_LIMIT = 20;
	localparam int SEED = 32'h4e760e67;
	localparam int BPM [8] = '{40, 60, 80, 100, 120, 140, 180, 220};
	// lit segments gfedcba for digits 0..F
	localparam logic [6:0] LIT [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
		7'h7f, 7'h67, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

	logic                   clk;
	logic                   resetn;
	logic                   select;
	logic                   back;
	logic [2:0]             speed;
	logic [1:0]             mode_sel;
	guitar_pkg::pick_t      pick;
	guitar_pkg::note_word_t note;
	guitar_pkg::seg_t       note_lo_seg;
	guitar_pkg::seg_t       note_hi_seg;
	guitar_pkg::seg_t       state_seg;

	int                     seed;
	int                     errors;
	int                     checks;
	int                     tests;
	guitar_pkg::pick_t      pats [NPAT];
	guitar_pkg::note_word_t words [NPAT];  // expected word for each pattern

	guitar_recorder #(
		.clk_hz(CLK_HZ)
	) dut0 (
		.clk        (clk),
		.resetn     (resetn),
		.select     (select),
		.back       (back),
		.speed      (speed),
		.mode_sel   (mode_sel),
		.pick       (pick),
		.note       (note),
		.note_lo_seg(note_lo_seg),
		.note_hi_seg(note_hi_seg),
		.state_seg  (state_seg)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// highest pressed bar picks the row, strings land in that row
	function automatic guitar_pkg::note_word_t encode_note(input guitar_pkg::pick_t p);
		int row;
		row = 0;
		for (int b = 0; b < 4; b++) begin
			if (p.frets[b])
				row = b + 1;
		end
		return guitar_pkg::note_word_t'(32'(p.strings) << (6 * row));
	endfunction

	function automatic logic [3:0] onehot_digit_of(input logic [15:0] half);
		int ones;
		logic [3:0] pos;
		ones = 0;
		pos = 4'h0;
		for (int k = 0; k < 16; k++) begin
			if (half[k]) begin
				ones++;
				pos = 4'(k);
			end
		end
		return (ones == 1) ? pos : 4'hF;
	endfunction

	function automatic guitar_pkg::seg_t seg_pattern(input logic [3:0] digit);
		return ~LIT[digit];  // display is active low
	endfunction

	function automatic int beat_period(input logic [2:0] spd);
		return CLK_HZ * 60 / BPM[spd];
	endfunction

	function automatic guitar_pkg::pick_t make_pick(input logic [5:0] s, input logic [3:0] f);
		guitar_pkg::pick_t p;
		p.strings = s;
		p.frets = f;
		return p;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_note(input guitar_pkg::note_word_t got, input guitar_pkg::note_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED note got %h expected %h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_seg(input string name, input guitar_pkg::seg_t got,
			input guitar_pkg::seg_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_state_seg(input guitar_pkg::seg_t got, input logic [3:0] code);
		checks++;
		if (got !== seg_pattern(code)) begin
			errors++;
			$display("CHECK FAILED state_seg got %h expected %h", got, seg_pattern(code));
		end
	endtask

	task automatic compare_interval(input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED beat interval got %h expected %h", got, exp);
		end
	endtask

	task automatic verify_note_display(input guitar_pkg::note_word_t exp);
		check_note(note, exp);
		check_seg("note_lo_seg", note_lo_seg, seg_pattern(onehot_digit_of(exp[15:0])));
		check_seg("note_hi_seg", note_hi_seg, seg_pattern(onehot_digit_of(exp[31:16])));
	endtask

	task automatic tap_button(input logic is_back);
		if (is_back)
			back = 1'b1;
		else
			select = 1'b1;
		repeat (HOLD) next_cycle();
		select = 1'b0;
		back = 1'b0;
		next_cycle();
	endtask

	task automatic wait_state(input logic [3:0] code);
		int n;
		n = 0;
		while (state_seg !== seg_pattern(code) && n < STATE_LIMIT) begin
			next_cycle();
			n++;
		end
		checks++;
		if (state_seg !== seg_pattern(code)) begin
			errors++;
			$display("state did not reach code %0d within %0d cycles", code, STATE_LIMIT);
		end
	endtask

	task automatic wait_note_change(input guitar_pkg::note_word_t from, input int limit,
			output int cycles, output logic seen);
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < limit) begin
			next_cycle();
			cycles++;
			seen = (note !== from);
		end
		if (!seen) begin
			errors++;
			$display("note did not change within %0d cycles", limit);
		end
	endtask

	task automatic start_session(input logic [1:0] mode, input logic [3:0] wait_code,
			input logic [3:0] run_code);
		mode_sel = mode;
		tap_button(1'b0);
		wait_state(wait_code);
		check_note(note, '0);
		tap_button(1'b0);
		wait_state(run_code);
	endtask

	task automatic stop_session(input logic [3:0] stop_code);
		tap_button(1'b0);
		wait_state(stop_code);
		next_cycle();
		check_note(note, '0);  // both mode levels low here
		tap_button(1'b1);
		wait_state(4'd0);
		check_note(note, '0);
	endtask

	// walk the expected words in order, one per note change
	task automatic follow_notes(input logic advance_pick);
		guitar_pkg::note_word_t from;
		int cycles;
		logic seen;
		from = '0;
		for (int i = 0; i < NPAT; i++) begin
			wait_note_change(from, 2 * beat_period(speed), cycles, seen);
			if (!seen)
				return;
			verify_note_display(words[i]);
			from = words[i];
			if (advance_pick && i < NPAT - 1)
				pick = pats[i + 1];  // still inside the dead time
		end
	endtask

	task automatic measure_beats(input logic [2:0] spd, inout guitar_pkg::note_word_t from);
		int cycles;
		logic seen;
		speed = spd;  // applies from the next reload
		for (int k = 0; k < 3; k++) begin
			wait_note_change(from, 2 * beat_period(spd), cycles, seen);
			if (!seen)
				return;
			from = (pick == pats[0]) ? words[0] : words[NPAT - 1];
			verify_note_display(from);
			if (k > 0)
				compare_interval(cycles, beat_period(spd));  // first beat only resyncs
			pick = (pick == pats[0]) ? pats[NPAT - 1] : pats[0];
		end
	endtask

	task automatic build_patterns();
		int r;
		pats[0] = make_pick(6'b000001, 4'b0000);  // open string 0
		pats[1] = make_pick(6'b000100, 4'b0000);
		r = $random(seed);
		pats[2] = make_pick(6'(r) | 6'b000001, 4'(r >> 8));  // bit 0 set, neighbours clear it
		pats[3] = make_pick(6'b001000, 4'b0001);  // bar 1
		r = $random(seed);
		pats[4] = make_pick(6'(r) | 6'b000001, 4'(r >> 8));
		pats[5] = make_pick(6'b000010, 4'b0100);  // bar 3
		pats[6] = make_pick(6'b100000, 4'b1011);  // bar 4 wins
		pats[7] = make_pick(6'b110000, 4'b0110);  // bar 3 over bar 2
		for (int i = 0; i < NPAT; i++)
			words[i] = encode_note(pats[i]);
	endtask

	task automatic report_test(input string name, input int start);
		tests++;
		if (errors == start)
			$display("test %s passed", name);
		else
			$display("test %s failed with %0d errors", name, errors - start);
	endtask

	task automatic after_reset();
		int start;
		start = errors;
		check_state_seg(state_seg, 4'd0);
		verify_note_display('0);
		report_test("reset", start);
	endtask

	task automatic navigate_menus();
		int start;
		start = errors;
		mode_sel = guitar_pkg::MODE_RECORD;
		tap_button(1'b0);
		wait_state(4'd2);
		tap_button(1'b1);
		wait_state(4'd0);
		mode_sel = 2'd2;  // no such mode
		tap_button(1'b0);
		next_cycle();
		check_state_seg(state_seg, 4'd0);
		mode_sel = guitar_pkg::MODE_PLAY;
		tap_button(1'b0);
		wait_state(4'd8);
		tap_button(1'b1);
		wait_state(4'd0);
		report_test("navigation", start);
	endtask

	task automatic record_notes();
		int start;
		start = errors;
		start_session(guitar_pkg::MODE_RECORD, 4'd2, 4'd4);
		follow_notes(1'b1);
		stop_session(4'd6);
		report_test("recording", start);
	endtask

	task automatic replay_notes();
		int start;
		start = errors;
		start_session(guitar_pkg::MODE_PLAY, 4'd8, 4'd10);
		follow_notes(1'b0);
		stop_session(4'd12);
		report_test("playback", start);
	endtask

	task automatic tempo_timing();
		int start;
		guitar_pkg::note_word_t from;
		start = errors;
		from = '0;
		pick = pats[NPAT - 1];
		start_session(guitar_pkg::MODE_RECORD, 4'd2, 4'd4);
		measure_beats(3'd7, from);
		measure_beats(3'd0, from);
		stop_session(4'd6);
		report_test("tempo", start);
	endtask

	initial begin
		seed = SEED;
		errors = 0;
		checks = 0;
		tests = 0;
		resetn = 1'b0;
		select = 1'b0;
		back = 1'b0;
		speed = 3'd7;
		mode_sel = guitar_pkg::MODE_PLAY;
		build_patterns();
		pick = pats[0];  // held from the start so the first beat is clean
		repeat (4) @(posedge clk);
		#2;
		resetn = 1'b1;
		after_reset();
		navigate_menus();
		record_notes();
		replay_notes();
		tempo_timing();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== src/guitar_recorder.sv ====
// all inputs active high and synchronous to clk; clk_hz sets the beat length, lower it for simulation
`timescale 1ns/100ps

module guitar_recorder #(
	parameter int unsigned clk_hz = 50_000_000
) (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   select,
	input  logic                   back,
	input  logic [2:0]             speed,
	input  logic [1:0]             mode_sel,
	input  guitar_pkg::pick_t      pick,
	output guitar_pkg::note_word_t note,
	output guitar_pkg::seg_t       note_lo_seg,
	output guitar_pkg::seg_t       note_hi_seg,
	output guitar_pkg::seg_t       state_seg
);

	logic                    sample_window;
	logic                    note_strobe;
	guitar_pkg::note_word_t  note_word;
	logic                    addr_clear;
	logic                    recording;
	logic                    playing;
	guitar_pkg::ctrl_state_t state;

	tempo_divider #(
		.clk_hz(clk_hz)
	) u_tempo (
		.clk          (clk),
		.resetn       (resetn),
		.speed        (speed),
		.sample_window(sample_window)
	);

	note_capture u_capture (
		.clk          (clk),
		.resetn       (resetn),
		.sample_window(sample_window),
		.pick         (pick),
		.note_strobe  (note_strobe),
		.note_word    (note_word)
	);

	note_memory u_memory (
		.clk        (clk),
		.resetn     (resetn),
		.addr_clear (addr_clear),
		.recording  (recording),
		.playing    (playing),
		.note_strobe(note_strobe),
		.note_word  (note_word),
		.note       (note)
	);

	mode_control u_control (
		.clk       (clk),
		.resetn    (resetn),
		.select    (select),
		.back      (back),
		.mode_sel  (mode_sel),
		.state     (state),
		.addr_clear(addr_clear),
		.recording (recording),
		.playing   (playing)
	);

	note_display u_display (
		.note       (note),
		.state      (state),
		.note_lo_seg(note_lo_seg),
		.note_hi_seg(note_hi_seg),
		.state_seg  (state_seg)
	);

endmodule

// ==== src/note_display.sv ====
// each half word shows a digit only when exactly one bit is set, otherwise F; outputs are active low
`timescale 1ns/100ps

module note_display (
	input  guitar_pkg::note_word_t  note,
	input  guitar_pkg::ctrl_state_t state,
	output guitar_pkg::seg_t        note_lo_seg,
	output guitar_pkg::seg_t        note_hi_seg,
	output guitar_pkg::seg_t        state_seg
);

	logic [15:0] half_lo;
	logic [15:0] half_hi;

	// position of the single set bit
	function automatic logic [3:0] onehot_digit(input logic [15:0] half);
		logic [3:0] digit;
		digit = 4'hF;
		if ($onehot(half)) begin
			for (int k = 0; k < 16; k++) begin
				if (half[k])
					digit = 4'(k);
			end
		end
		return digit;
	endfunction

	assign half_lo = note[15:0];
	assign half_hi = note[31:16];

	assign note_lo_seg = guitar_pkg::hex_seg(onehot_digit(half_lo));
	assign note_hi_seg = guitar_pkg::hex_seg(onehot_digit(half_hi));
	assign state_seg   = guitar_pkg::hex_seg(state);  // raw state code

endmodule

// ==== src/mode_control.sv ====
// buttons are expected debounced and active high; every action waits for select to be released
`timescale 1ns/100ps

module mode_control (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    select,
	input  logic                    back,
	input  logic [1:0]              mode_sel,
	output guitar_pkg::ctrl_state_t state,
	output logic                    addr_clear,
	output logic                    recording,
	output logic                    playing
);

	guitar_pkg::ctrl_state_t next_state;

	always_comb begin
		next_state = state;
		case (state)
			guitar_pkg::ST_SELECT:
				if (select)
					next_state = guitar_pkg::ST_SELECT_REL;
			guitar_pkg::ST_SELECT_REL:
				if (!select) begin
					if (mode_sel == guitar_pkg::MODE_PLAY)
						next_state = guitar_pkg::ST_WAIT_PLAY;
					else if (mode_sel == guitar_pkg::MODE_RECORD)
						next_state = guitar_pkg::ST_WAIT_REC;
					else
						next_state = guitar_pkg::ST_SELECT;  // unknown mode
				end

			// record branch
			guitar_pkg::ST_WAIT_REC:
				if (back)
					next_state = guitar_pkg::ST_SELECT;
				else if (select)
					next_state = guitar_pkg::ST_WAIT_REC_REL;
			guitar_pkg::ST_WAIT_REC_REL:
				if (!select)
					next_state = guitar_pkg::ST_RECORDING;
			guitar_pkg::ST_RECORDING:
				if (select)
					next_state = guitar_pkg::ST_RECORDING_REL;
			guitar_pkg::ST_RECORDING_REL:
				if (!select)
					next_state = guitar_pkg::ST_REC_STOP;
			guitar_pkg::ST_REC_STOP:
				if (select || back)
					next_state = guitar_pkg::ST_REC_STOP_REL;
			guitar_pkg::ST_REC_STOP_REL:
				if (!select)
					next_state = guitar_pkg::ST_END;

			// play branch
			guitar_pkg::ST_WAIT_PLAY:
				if (back)
					next_state = guitar_pkg::ST_SELECT;
				else if (select)
					next_state = guitar_pkg::ST_WAIT_PLAY_REL;
			guitar_pkg::ST_WAIT_PLAY_REL:
				if (!select)
					next_state = guitar_pkg::ST_PLAYING;
			guitar_pkg::ST_PLAYING:
				if (select)
					next_state = guitar_pkg::ST_PLAYING_REL;
			guitar_pkg::ST_PLAYING_REL:
				if (!select)
					next_state = guitar_pkg::ST_PLAY_STOP;
			guitar_pkg::ST_PLAY_STOP:
				if (select || back)
					next_state = guitar_pkg::ST_PLAY_STOP_REL;
			guitar_pkg::ST_PLAY_STOP_REL:
				if (!select)
					next_state = guitar_pkg::ST_END;

			guitar_pkg::ST_END:
				next_state = guitar_pkg::ST_SELECT;
			default:
				next_state = guitar_pkg::ST_SELECT;  // code 15 is unused
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			state <= guitar_pkg::ST_SELECT;
		else
			state <= next_state;
	end

	// address held at zero while waiting to start
	assign addr_clear = state inside {guitar_pkg::ST_WAIT_REC, guitar_pkg::ST_WAIT_REC_REL,
		guitar_pkg::ST_WAIT_PLAY, guitar_pkg::ST_WAIT_PLAY_REL};
	assign recording  = state inside {guitar_pkg::ST_RECORDING, guitar_pkg::ST_RECORDING_REL};
	assign playing    = state inside {guitar_pkg::ST_PLAYING, guitar_pkg::ST_PLAYING_REL};

endmodule

// ==== src/note_memory.sv ====
// recording wraps after 64 notes and overwrites the oldest; recording wins if both mode levels are high
`timescale 1ns/100ps

module note_memory (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   addr_clear,
	input  logic                   recording,
	input  logic                   playing,
	input  logic                   note_strobe,
	input  guitar_pkg::note_word_t note_word,
	output guitar_pkg::note_word_t note
);

	guitar_pkg::note_word_t mem [guitar_pkg::NOTE_DEPTH];
	guitar_pkg::note_addr_t addr;
	logic                   write_en;
	logic                   read_en;

	assign write_en = note_strobe & recording;
	assign read_en  = note_strobe & playing & ~recording;

	always_ff @(posedge clk) begin
		if (write_en)
			mem[addr] <= note_word;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			addr <= '0;
			note <= '0;
		end else begin
			if (addr_clear)
				addr <= '0;
			else if (write_en || read_en)
				addr <= addr + 1'b1;  // wraps after 63

			if (write_en)
				note <= note_word;  // echo the word being stored
			else if (read_en)
				note <= mem[addr];
			else if (!recording && !playing)
				note <= '0;
		end
	end

endmodule

// ==== src/note_capture.sv ====
// contacts are sampled every cycle of the window with no debounce; several bars keep only the highest
`timescale 1ns/100ps

module note_capture (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   sample_window,
	input  guitar_pkg::pick_t      pick,
	output logic                   note_strobe,
	output guitar_pkg::note_word_t note_word
);

	guitar_pkg::string_mask_t held_strings;
	guitar_pkg::row_flags_t   held_rows;
	guitar_pkg::row_flags_t   row_pick;
	logic                     window_d;
	logic                     window_fall;

	// highest pressed bar wins, open string when none
	always_comb begin
		row_pick = '0;
		if (pick.frets[3])
			row_pick[4] = 1'b1;
		else if (pick.frets[2])
			row_pick[3] = 1'b1;
		else if (pick.frets[1])
			row_pick[2] = 1'b1;
		else if (pick.frets[0])
			row_pick[1] = 1'b1;
		else
			row_pick[0] = 1'b1;
	end

	assign window_fall = window_d & ~sample_window;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			window_d     <= 1'b0;
			note_strobe  <= 1'b0;
			held_strings <= '0;
			held_rows    <= '0;
		end else begin
			window_d    <= sample_window;
			note_strobe <= window_fall;
			if (window_fall) begin
				held_strings <= '0;  // start fresh for next beat
				held_rows    <= '0;
			end else if (sample_window) begin
				held_strings <= held_strings | pick.strings;
				held_rows    <= held_rows | row_pick;
			end
		end
	end

	// encode on the window edge
	always_ff @(posedge clk) begin
		if (window_fall) begin
			note_word.pad  <= 2'b00;
			note_word.row0 <= {6{held_rows[0]}} & held_strings;
			note_word.row1 <= {6{held_rows[1]}} & held_strings;
			note_word.row2 <= {6{held_rows[2]}} & held_strings;
			note_word.row3 <= {6{held_rows[3]}} & held_strings;
			note_word.row4 <= {6{held_rows[4]}} & held_strings;
		end
	end

endmodule

// ==== src/tempo_divider.sv ====
// speed changes take effect at the next reload; counter is 32 bits, so clk_hz*60/40 must stay below 2^32
`timescale 1ns/100ps

module tempo_divider #(
	parameter int unsigned clk_hz = 50_000_000
) (
	input  logic       clk,
	input  logic       resetn,
	input  logic [2:0] speed,
	output logic       sample_window
);

	logic [31:0] period_tab [0:7];
	logic [31:0] period;
	logic [31:0] dead_time;
	logic [31:0] count;

	// beat length in cycles for each tempo
	for (genvar i = 0; i < 8; i++) begin : g_period
		assign period_tab[i] = 32'((64'(clk_hz) * 64'd60) / 64'(guitar_pkg::TEMPO_BPM[i]));
	end

	assign period    = period_tab[speed];
	assign dead_time = 32'(clk_hz / guitar_pkg::WINDOW_DIV);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			count         <= period - 32'd1;
			sample_window <= 1'b0;
		end else begin
			if (count == '0)
				count <= period - 32'd1;  // reload for next beat
			else
				count <= count - 32'd1;
			sample_window <= (count >= dead_time);  // low during dead time at beat start
		end
	end

endmodule

// ==== src/guitar_pkg.sv ====
// contact inputs arrive active high; segment outputs are active low; tempo math assumes clk_hz*60 fits 64 bits
package guitar_pkg;

	typedef logic [5:0] string_mask_t;  // bit 0 is string 0
	typedef logic [3:0] fret_mask_t;    // bit 0 is bar 1
	typedef logic [4:0] row_flags_t;    // row 0 open, rows 1..4 bars

	// one sample of the fretboard contacts
	typedef struct packed {
		string_mask_t strings;
		fret_mask_t   frets;
	} pick_t;

	typedef struct packed {
		logic [1:0]   pad;   // always zero
		string_mask_t row4;
		string_mask_t row3;
		string_mask_t row2;
		string_mask_t row1;
		string_mask_t row0;  // bits 5..0
	} note_word_t;

	typedef logic [6:0] seg_t;  // active low, bit 6 is segment g

	typedef enum logic [3:0] {
		ST_SELECT          = 4'd0,
		ST_SELECT_REL      = 4'd1,
		ST_WAIT_REC        = 4'd2,
		ST_WAIT_REC_REL    = 4'd3,
		ST_RECORDING       = 4'd4,
		ST_RECORDING_REL   = 4'd5,
		ST_REC_STOP        = 4'd6,
		ST_REC_STOP_REL    = 4'd7,
		ST_WAIT_PLAY       = 4'd8,
		ST_WAIT_PLAY_REL   = 4'd9,
		ST_PLAYING         = 4'd10,
		ST_PLAYING_REL     = 4'd11,
		ST_PLAY_STOP       = 4'd12,
		ST_PLAY_STOP_REL   = 4'd13,
		ST_END             = 4'd14
	} ctrl_state_t;

	localparam logic [1:0] MODE_PLAY   = 2'd0;
	localparam logic [1:0] MODE_RECORD = 2'd1;

	// beats per minute, indexed by speed switch
	localparam int unsigned TEMPO_BPM [0:7] = '{40, 60, 80, 100, 120, 140, 180, 220};
	localparam int unsigned WINDOW_DIV = 5000;  // dead time is clk_hz / WINDOW_DIV cycles
	localparam int unsigned NOTE_DEPTH = 64;

	typedef logic [$clog2(NOTE_DEPTH)-1:0] note_addr_t;

	localparam seg_t SEG_BLANK = 7'h7f;

	function automatic seg_t hex_seg(input logic [3:0] digit);
		seg_t seg;
		case (digit)
			4'h0: seg = 7'b100_0000;
			4'h1: seg = 7'b111_1001;
			4'h2: seg = 7'b010_0100;
			4'h3: seg = 7'b011_0000;
			4'h4: seg = 7'b001_1001;
			4'h5: seg = 7'b001_0010;
			4'h6: seg = 7'b000_0010;
			4'h7: seg = 7'b111_1000;
			4'h8: seg = 7'b000_0000;
			4'h9: seg = 7'b001_1000;
			4'hA: seg = 7'b000_1000;
			4'hB: seg = 7'b000_0011;
			4'hC: seg = 7'b100_0110;
			4'hD: seg = 7'b010_0001;
			4'hE: seg = 7'b000_0110;
			4'hF: seg = 7'b000_1110;
			default: seg = SEG_BLANK;
		endcase
		return seg;
	endfunction

endpackage
